//--- filelist.f
hdl/spi_cfg_pkg.sv
hdl/spi_xfer_pkg.sv
hdl/spi_cfg_regs.sv
hdl/spi_csn_seq.sv
hdl/spi_shift_engine.sv
hdl/spi_master_top.sv
tb/tb_spi_master.sv

//--- hdl/spi_cfg_pkg.sv
package spi_cfg_pkg;

	// Field widths of the configuration struct
	localparam int CFG_DIV_W = 8;
	localparam int CFG_DLY_W = 16;

	// Register addresses seen by the host
	typedef enum logic [2:0] {
		ADDR_CTRL  = 3'd0,
		ADDR_DIV   = 3'd1,
		ADDR_LEAD  = 3'd2,
		ADDR_TRAIL = 3'd3,
		ADDR_TXD   = 3'd4,
		// Read only from here on
		ADDR_RXD   = 3'd5,
		ADDR_STAT  = 3'd6
	} reg_addr_e;

	// Half period minus one, then chip-select lead and trail delays
	typedef struct packed {
		logic [CFG_DIV_W-1:0] div;
		logic [CFG_DLY_W-1:0] lead;
		logic [CFG_DLY_W-1:0] trail;
	} spi_cfg_t;

endpackage

//--- hdl/spi_cfg_regs.sv
`timescale 1ns/1ps

module spi_cfg_regs #(
	parameter int DATA_W = 8,
	parameter int DLY_W  = 16,
	parameter int DIV_W  = 8
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr_en,
	input  logic                       rd_en,
	input  spi_cfg_pkg::reg_addr_e     addr,
	input  logic [31:0]                wdata,
	output logic [31:0]                rdata,
	output spi_cfg_pkg::spi_cfg_t      cfg,
	output logic [DATA_W-1:0]          tx_word,
	output logic                       start,
	input  logic [DATA_W-1:0]          rx_word,
	input  logic                       rx_valid,
	input  spi_xfer_pkg::xfer_status_t status
);
	import spi_cfg_pkg::*;

	logic [DIV_W-1:0]  div_q;
	logic [DLY_W-1:0]  lead_q;
	logic [DLY_W-1:0]  trail_q;
	logic [DATA_W-1:0] txd_q;
	logic [DATA_W-1:0] rxd_q;
	logic              done_seen;
	logic              locked;

	// Start pulse counts as busy, since the sequencer sees it one cycle late
	assign locked = status.busy | start;

	////////////////////////////////////////////////////////////////////////////
	// Host writes
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			div_q   <= '0;
			lead_q  <= '0;
			trail_q <= '0;
			txd_q   <= '0;
			start   <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_en && !locked) begin
				case (addr)
					ADDR_CTRL:  start   <= wdata[0];
					ADDR_DIV:   div_q   <= wdata[DIV_W-1:0];
					ADDR_LEAD:  lead_q  <= wdata[DLY_W-1:0];
					ADDR_TRAIL: trail_q <= wdata[DLY_W-1:0];
					ADDR_TXD:   txd_q   <= wdata[DATA_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Receive capture and sticky done flag
	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_q     <= '0;
			done_seen <= 1'b0;
		end else begin
			if (rx_valid)
				rxd_q <= rx_word;
			// A done in the same cycle as the status read wins
			if (status.done)
				done_seen <= 1'b1;
			else if (rd_en && addr == ADDR_STAT)
				done_seen <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host reads, one cycle latency
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else if (rd_en) begin
			case (addr)
				ADDR_DIV:   rdata <= 32'(div_q);
				ADDR_LEAD:  rdata <= 32'(lead_q);
				ADDR_TRAIL: rdata <= 32'(trail_q);
				ADDR_TXD:   rdata <= 32'(txd_q);
				ADDR_RXD:   rdata <= 32'(rxd_q);
				ADDR_STAT:  rdata <= {30'd0, done_seen, status.busy};
				default:    rdata <= '0;
			endcase
		end
	end

	assign cfg.div   = CFG_DIV_W'(div_q);
	assign cfg.lead  = CFG_DLY_W'(lead_q);
	assign cfg.trail = CFG_DLY_W'(trail_q);
	assign tx_word   = txd_q;

	// The sequencer must be idle whenever a new frame is launched
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		$rose(start) |-> !status.busy);

endmodule

//--- hdl/spi_csn_seq.sv
`timescale 1ns/1ps

module spi_csn_seq #(
	parameter int DLY_W = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic [DLY_W-1:0]           lead,
	input  logic [DLY_W-1:0]           trail,
	input  logic                       txd_cmpt,
	output logic                       txd_en,
	output logic                       csn,
	output spi_xfer_pkg::xfer_status_t status
);
	import spi_xfer_pkg::*;

	seq_state_e       state;
	logic [DLY_W-1:0] lead_cnt;
	logic [DLY_W-1:0] trail_cnt;
	logic             lead_end;
	logic             trail_end;
	logic             done_q;

	assign lead_end  = (state == CS_LEAD) && (lead_cnt == lead);
	assign trail_end = (state == CS_TRAIL) && (trail_cnt == trail);

	////////////////////////////////////////////////////////////////////////////
	// Delay counters, held at zero outside their own state
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst || state != CS_LEAD)
			lead_cnt <= '0;
		else
			lead_cnt <= lead_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst || state != CS_TRAIL)
			trail_cnt <= '0;
		else
			trail_cnt <= trail_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= CS_IDLE;
			csn    <= 1'b1;
			txd_en <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				CS_IDLE: begin
					if (start) begin
						csn   <= 1'b0;
						state <= CS_LEAD;
					end
				end
				CS_LEAD: begin
					if (lead_end) begin
						txd_en <= 1'b1;
						state  <= CS_XFER;
					end
				end
				// Shift engine owns the bus until it reports the word
				CS_XFER: begin
					if (txd_cmpt) begin
						txd_en <= 1'b0;
						state  <= CS_TRAIL;
					end
				end
				CS_TRAIL: begin
					if (trail_end) begin
						csn   <= 1'b1;
						state <= CS_DONE;
					end
				end
				CS_DONE: begin
					done_q <= 1'b1;
					state  <= CS_IDLE;
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

	// Busy covers the done pulse so done_seen is set once busy drops
	assign status.busy = (state != CS_IDLE) | done_q;
	assign status.done = done_q;

	a_txd_en_csn: assert property (@(posedge clk) disable iff (rst)
		txd_en |-> !csn);

	a_cmpt_in_xfer: assert property (@(posedge clk) disable iff (rst)
		txd_cmpt |-> state == CS_XFER);

endmodule

//--- hdl/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top #(
	parameter int DATA_W = 8,
	parameter int DLY_W  = spi_cfg_pkg::CFG_DLY_W,
	parameter int DIV_W  = spi_cfg_pkg::CFG_DIV_W
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  logic                   rd_en,
	input  spi_cfg_pkg::reg_addr_e addr,
	input  logic [31:0]            wdata,
	output logic [31:0]            rdata,
	output logic                   csn,
	output logic                   sclk,
	output logic                   mosi,
	input  logic                   miso
);
	import spi_cfg_pkg::*;
	import spi_xfer_pkg::*;

	spi_cfg_t          cfg;
	xfer_status_t      status;
	logic [DATA_W-1:0] tx_word;
	logic [DATA_W-1:0] rx_word;
	logic              start;
	logic              rx_valid;
	logic              txd_en;
	logic              txd_cmpt;

	////////////////////////////////////////////////////////////////////////////
	// Register block, sequencer, shift engine
	////////////////////////////////////////////////////////////////////////////
	spi_cfg_regs #(
		.DATA_W (DATA_W),
		.DLY_W  (DLY_W),
		.DIV_W  (DIV_W)
	) u_regs (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.rd_en    (rd_en),
		.addr     (addr),
		.wdata    (wdata),
		.rdata    (rdata),
		.cfg      (cfg),
		.tx_word  (tx_word),
		.start    (start),
		.rx_word  (rx_word),
		.rx_valid (rx_valid),
		.status   (status)
	);

	spi_csn_seq #(
		.DLY_W (DLY_W)
	) u_seq (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.lead     (cfg.lead[DLY_W-1:0]),
		.trail    (cfg.trail[DLY_W-1:0]),
		.txd_cmpt (txd_cmpt),
		.txd_en   (txd_en),
		.csn      (csn),
		.status   (status)
	);

	spi_shift_engine #(
		.DATA_W (DATA_W),
		.DIV_W  (DIV_W)
	) u_shift (
		.clk      (clk),
		.rst      (rst),
		.txd_en   (txd_en),
		.div      (cfg.div[DIV_W-1:0]),
		.tx_word  (tx_word),
		.sclk     (sclk),
		.mosi     (mosi),
		.miso     (miso),
		.txd_cmpt (txd_cmpt),
		.rx_word  (rx_word),
		.rx_valid (rx_valid)
	);

endmodule

//--- hdl/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine #(
	parameter int DATA_W = 8,
	parameter int DIV_W  = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              txd_en,
	input  logic [DIV_W-1:0]  div,
	input  logic [DATA_W-1:0] tx_word,
	output logic              sclk,
	output logic              mosi,
	input  logic              miso,
	output logic              txd_cmpt,
	output logic [DATA_W-1:0] rx_word,
	output logic              rx_valid
);
	import spi_xfer_pkg::*;

	localparam int BIT_W = $clog2(DATA_W + 1);

	shift_state_e      state;
	logic [DIV_W-1:0]  hp_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	logic [DATA_W-1:0] tx_sr;
	logic [DATA_W-1:0] rx_sr;
	logic              half_end;

	// Half period is div+1 clk cycles
	assign half_end = (hp_cnt == div);

	////////////////////////////////////////////////////////////////////////////
	// Half-period counter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst || state == SH_IDLE || state == SH_END || half_end)
			hp_cnt <= '0;
		else
			hp_cnt <= hp_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Mode 0 shifter, MSB first
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= SH_IDLE;
			sclk     <= 1'b0;
			bit_cnt  <= '0;
			tx_sr    <= '0;
			rx_sr    <= '0;
			txd_cmpt <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			txd_cmpt <= 1'b0;
			rx_valid <= 1'b0;
			case (state)
				SH_IDLE: begin
					// Preload, so the MSB is already on mosi when txd_en rises
					tx_sr   <= tx_word;
					bit_cnt <= '0;
					if (txd_en)
						state <= SH_LOW;
				end
				SH_LOW: begin
					if (half_end) begin
						sclk  <= 1'b1;
						rx_sr <= {rx_sr[DATA_W-2:0], miso};
						state <= SH_HIGH;
					end
				end
				SH_HIGH: begin
					if (half_end) begin
						sclk    <= 1'b0;
						tx_sr   <= {tx_sr[DATA_W-2:0], 1'b0};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_W - 1)) begin
							txd_cmpt <= 1'b1;
							rx_valid <= 1'b1;
							state    <= SH_END;
						end else begin
							state <= SH_LOW;
						end
					end
				end
				// Hold off until the sequencer drops the enable
				SH_END: begin
					if (!txd_en)
						state <= SH_IDLE;
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

	assign mosi    = tx_sr[DATA_W-1];
	assign rx_word = rx_sr;

	a_sclk_idle: assert property (@(posedge clk) disable iff (rst)
		!txd_en |-> !sclk);

endmodule

//--- hdl/spi_xfer_pkg.sv
package spi_xfer_pkg;

	// Chip-select sequencer
	typedef enum logic [2:0] {
		CS_IDLE,
		CS_LEAD,
		CS_XFER,
		CS_TRAIL,
		CS_DONE
	} seq_state_e;

	// Shift engine, one word per enable
	typedef enum logic [1:0] {
		SH_IDLE,
		SH_LOW,
		SH_HIGH,
		SH_END
	} shift_state_e;

	typedef struct packed {
		logic busy;
		logic done;
	} xfer_status_t;

endpackage

//--- tb/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;
	import spi_cfg_pkg::*;

	localparam int DATA_W  = 8;
	localparam int MAX_DIV = 7;
	localparam int MAX_DLY = 40;
	localparam int N_XFER  = 9;
	// Worst case frame plus register traffic around it
	localparam int XFER_CYC    = 2 * DATA_W * (MAX_DIV + 1) + 2 * MAX_DLY + 40;
	localparam int TIMEOUT_CYC = 2 * (N_XFER * XFER_CYC + 100);

	logic        clk = 1'b0;
	logic        rst;
	logic        wr_en;
	logic        rd_en;
	reg_addr_e   addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        csn;
	logic        sclk;
	logic        mosi;
	logic        miso;

	logic              slave_mode = 1'b0;
	logic [DATA_W-1:0] slave_word = '0;
	logic [DATA_W-1:0] slave_sr = '0;
	logic [DATA_W-1:0] mosi_bits = '0;
	logic              prev_csn = 1'b1;
	logic              prev_sclk = 1'b0;
	int cyc_now = 0;
	int t_csn_fall = 0;
	int t_sclk_fall = 0;
	int lead_meas = 0;
	int trail_meas = 0;
	int frame_rises = 0;
	int rises_last = 0;
	int frames = 0;
	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;

	always #10 clk = ~clk;

	spi_master_top #(
		.DATA_W (DATA_W),
		.DLY_W  (16),
		.DIV_W  (8)
	) DUT (
		.clk   (clk),
		.rst   (rst),
		.wr_en (wr_en),
		.rd_en (rd_en),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.csn   (csn),
		.sclk  (sclk),
		.mosi  (mosi),
		.miso  (miso)
	);

	////////////////////////////////////////////////////////////////////////////
	// Slave model and edge monitor
	////////////////////////////////////////////////////////////////////////////
	assign miso = slave_mode ? slave_sr[DATA_W-1] : mosi;

	// First slave bit goes out as soon as csn falls
	always @(negedge csn)
		slave_sr = slave_word;

	always @(negedge sclk)
		if (!csn)
			slave_sr = {slave_sr[DATA_W-2:0], 1'b0};

	always @(posedge clk) begin
		if (!rst) begin
			if (prev_csn && !csn) begin
				t_csn_fall = cyc_now;
				frame_rises = 0;
			end
			if (!prev_sclk && sclk) begin
				if (frame_rises == 0)
					lead_meas = cyc_now - t_csn_fall;
				frame_rises = frame_rises + 1;
				mosi_bits = {mosi_bits[DATA_W-2:0], mosi};
			end
			if (prev_sclk && !sclk)
				t_sclk_fall = cyc_now;
			if (!prev_csn && csn) begin
				trail_meas = cyc_now - t_sclk_fall;
				rises_last = frame_rises;
				frames = frames + 1;
			end
		end
		prev_csn = csn;
		prev_sclk = sclk;
		cyc_now = cyc_now + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Register access
	////////////////////////////////////////////////////////////////////////////
	task automatic reg_write(input reg_addr_e a, input logic [31:0] d);
		@(posedge clk);
		wr_en <= 1'b1;
		addr  <= a;
		wdata <= d;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic reg_read(input reg_addr_e a, output logic [31:0] d);
		@(posedge clk);
		rd_en <= 1'b1;
		addr  <= a;
		@(posedge clk);
		rd_en <= 1'b0;
		@(negedge clk);
		d = rdata;
	endtask

	// Last status read is returned, since that read clears done_seen
	task automatic wait_idle(output logic [31:0] stat);
		stat = 32'h1;
		while (stat[0])
			reg_read(ADDR_STAT, stat);
	endtask

	task automatic run_xfer(input int div, input int lead, input int trail,
			input logic [DATA_W-1:0] tx, output logic [31:0] rxd,
			output logic [31:0] stat);
		reg_write(ADDR_DIV, div);
		reg_write(ADDR_LEAD, lead);
		reg_write(ADDR_TRAIL, trail);
		reg_write(ADDR_TXD, tx);
		reg_write(ADDR_CTRL, 32'h1);
		wait_idle(stat);
		reg_read(ADDR_RXD, rxd);
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int e0);
		if (errors == e0) begin
			$display("%s: ok", name);
			n_pass++;
		end else begin
			$display("%s: %0d error(s)", name, errors - e0);
			n_fail++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic reset_values();
		int e0;
		logic [31:0] d;
		e0 = errors;
		expect_eq("csn", csn, 1);
		expect_eq("sclk", sclk, 0);
		reg_read(ADDR_STAT, d);
		expect_eq("stat", d, 0);
		report_test("reset", e0);
	endtask

	task automatic loopback_words();
		int e0;
		int i;
		logic [DATA_W-1:0] tx;
		logic [31:0] rxd;
		logic [31:0] stat;
		e0 = errors;
		slave_mode = 1'b0;
		for (i = 0; i < 3; i++) begin
			tx = DATA_W'($urandom);
			run_xfer($urandom_range(0, MAX_DIV), $urandom_range(0, 20),
				$urandom_range(0, 20), tx, rxd, stat);
			expect_eq("rxd", rxd, tx);
			expect_eq("sclk_rises", rises_last, DATA_W);
		end
		report_test("loopback", e0);
	endtask

	task automatic slave_word_xfer();
		int e0;
		logic [DATA_W-1:0] tx;
		logic [31:0] rxd;
		logic [31:0] stat;
		e0 = errors;
		slave_mode = 1'b1;
		slave_word = DATA_W'($urandom);
		tx = DATA_W'($urandom);
		run_xfer($urandom_range(0, MAX_DIV), 3, 3, tx, rxd, stat);
		expect_eq("rxd", rxd, slave_word);
		expect_eq("mosi_bits", mosi_bits, tx);
		expect_eq("sclk_rises", rises_last, DATA_W);
		slave_mode = 1'b0;
		report_test("slave_word", e0);
	endtask

	task automatic cs_delays();
		int e0;
		int dly [3] = '{0, 5, MAX_DLY};
		logic [31:0] rxd;
		logic [31:0] stat;
		e0 = errors;
		foreach (dly[i]) begin
			run_xfer(1, dly[i], dly[i], DATA_W'(8'h5A + i), rxd, stat);
			if (lead_meas < dly[i] + 1) begin
				$display("Lead delay too short: %0d cycles for lead %0d",
					lead_meas, dly[i]);
				errors++;
			end
			if (trail_meas < dly[i] + 1) begin
				$display("Trail delay too short: %0d cycles for trail %0d",
					trail_meas, dly[i]);
				errors++;
			end
		end
		report_test("delays", e0);
	endtask

	task automatic busy_lockout();
		int e0;
		int f0;
		logic [31:0] d;
		e0 = errors;
		reg_write(ADDR_DIV, 3);
		reg_write(ADDR_LEAD, 10);
		reg_write(ADDR_TRAIL, 4);
		f0 = frames;
		reg_write(ADDR_CTRL, 32'h1);
		// Both land while the frame is running
		reg_write(ADDR_CTRL, 32'h1);
		reg_write(ADDR_DIV, 9);
		wait_idle(d);
		repeat (20) @(posedge clk);
		reg_read(ADDR_DIV, d);
		expect_eq("div", d, 3);
		expect_eq("frames", frames - f0, 1);
		report_test("busy", e0);
	endtask

	task automatic done_status();
		int e0;
		logic [31:0] rxd;
		logic [31:0] stat;
		e0 = errors;
		run_xfer(0, 2, 2, DATA_W'($urandom), rxd, stat);
		expect_eq("done_seen", stat[1], 1);
		reg_read(ADDR_STAT, stat);
		expect_eq("stat", stat, 0);
		report_test("status", e0);
	endtask

	initial begin
		void'($urandom(84));
		rst = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		addr = ADDR_CTRL;
		wdata = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		reset_values();
		loopback_words();
		slave_word_xfer();
		cs_delays();
		busy_lockout();
		done_status();
		$display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("Test failed");
		$finish;
	end

endmodule
